//--- rtl/cpu6_consts.svh
`ifndef CPU6_CONSTS_SVH
`define CPU6_CONSTS_SVH

`default_nettype none

// data path and csr index widths
`define CPU6_XLEN      32
`define CPU6_CSR_SIZE  12

// fixed direct-mode trap entry
`define CPU6_MTVEC_TRAP_BASE 32'h0000_0100

// standard machine csr indices
`define CPU6_CSR_MSTATUS 12'h300
`define CPU6_CSR_MIE     12'h304
`define CPU6_CSR_MEPC    12'h341
`define CPU6_CSR_MIP     12'h344

// custom machine r/w indices for the timer
`define CPU6_CSR_MTIMECMP 12'h7C0
`define CPU6_CSR_MTIME    12'h7C1

// compare value that no 64-bit mtime reaches in practice
`define CPU6_MTIMECMP_RST 64'hFFFF_FFFF_FFFF_FFFF

`default_nettype wire

`endif

//--- rtl/cpu6_pkg.sv
`include "cpu6_consts.svh"
`default_nettype none

package cpu6_pkg;

   // one data word
   typedef logic [`CPU6_XLEN-1:0] xlen_t;

   // one csr index
   typedef logic [`CPU6_CSR_SIZE-1:0] csr_idx_t;

   // what the commit stage hands over with each instruction
   typedef enum logic [1:0] {
      op_plain  = 2'd0,
      op_csr_rd = 2'd1,
      op_csr_wr = 2'd2,
      op_mret   = 2'd3
   } commit_op_e;

   // trap controller boundary state
   typedef enum logic [1:0] {
      st_run    = 2'd0,
      st_enter  = 2'd1,
      st_return = 2'd2
   } trap_state_e;

endpackage

`default_nettype wire

//--- rtl/cpu6_csr.sv
`timescale 1ns/10ps
`include "cpu6_consts.svh"
`default_nettype none

module cpu6_csr (
   input  logic               clk,
   input  logic               rst_n,

   input  logic               csr_rd_en,
   input  logic               csr_wr_en,
   input  cpu6_pkg::csr_idx_t csr_idx,
   input  cpu6_pkg::xlen_t    csr_write_dat,
   output cpu6_pkg::xlen_t    csr_read_dat,

   input  logic               mret_ena,
   input  logic               trap_take,
   input  logic               tmr_pend,

   input  cpu6_pkg::xlen_t    excp_mepc,
   input  logic               excp_mepc_ena,
   input  cpu6_pkg::xlen_t    timer_rd_dat,

   output logic               csr_mtie_r,
   output logic               csr_mstatus_mie_r,
   output cpu6_pkg::xlen_t    csr_mtvec,
   output cpu6_pkg::xlen_t    csr_mepc
);

   import cpu6_pkg::*;

   logic  sel_mstatus;
   logic  sel_mie;
   logic  sel_mepc;
   logic  sel_mip;
   logic  wr_mstatus;
   logic  wr_mie;
   logic  wr_mepc;
   xlen_t mepc_r;
   logic  mtie_r;
   logic  mstatus_mie_r;
   logic  mtip_r;
   xlen_t mstatus_view;
   xlen_t mie_view;
   xlen_t mip_view;

   // direct mode only, single handler
   assign csr_mtvec = `CPU6_MTVEC_TRAP_BASE;

   // index decode
   assign sel_mstatus = (csr_idx == `CPU6_CSR_MSTATUS);
   assign sel_mie     = (csr_idx == `CPU6_CSR_MIE);
   assign sel_mepc    = (csr_idx == `CPU6_CSR_MEPC);
   assign sel_mip     = (csr_idx == `CPU6_CSR_MIP);

   assign wr_mstatus = sel_mstatus & csr_wr_en;
   assign wr_mie     = sel_mie & csr_wr_en;
   assign wr_mepc    = sel_mepc & csr_wr_en;

   // mepc, trap entry beats a csr write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mepc_r <= '0;
      end else if (excp_mepc_ena) begin
         mepc_r <= excp_mepc;
      end else if (wr_mepc) begin
         // instructions are at least 2-byte aligned
         mepc_r <= {csr_write_dat[`CPU6_XLEN-1:1], 1'b0};
      end
   end

   // mie.MTIE
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mtie_r <= 1'b0;
      end else if (wr_mie) begin
         mtie_r <= csr_write_dat[7];
      end
   end

   // mstatus.MIE: mret, then trap entry, then csr write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mstatus_mie_r <= 1'b0;
      end else if (mret_ena) begin
         mstatus_mie_r <= 1'b1;
      end else if (trap_take) begin
         mstatus_mie_r <= 1'b0;
      end else if (wr_mstatus) begin
         mstatus_mie_r <= csr_write_dat[3];
      end
   end

   // mip.MTIP follows the timer, read only
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mtip_r <= 1'b0;
      end else begin
         mtip_r <= tmr_pend;
      end
   end

   // register views as seen by software
   always_comb begin
      mstatus_view    = '0;
      mstatus_view[3] = mstatus_mie_r;
      mie_view        = '0;
      mie_view[7]     = mtie_r;
      mip_view        = '0;
      mip_view[7]     = mtip_r;
   end

   assign csr_mepc          = mepc_r;
   assign csr_mtie_r        = mtie_r;
   assign csr_mstatus_mie_r = mstatus_mie_r;

   // and-or read mux, timer word is already zero when not selected
   assign csr_read_dat = ({`CPU6_XLEN{sel_mstatus & csr_rd_en}} & mstatus_view)
                       | ({`CPU6_XLEN{sel_mie & csr_rd_en}} & mie_view)
                       | ({`CPU6_XLEN{sel_mepc & csr_rd_en}} & mepc_r)
                       | ({`CPU6_XLEN{sel_mip & csr_rd_en}} & mip_view)
                       | timer_rd_dat;

   // controller resolves interrupt vs mret before either strobe
   a_no_trap_and_mret: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(trap_take && mret_ena)
   );

endmodule

`default_nettype wire

//--- rtl/cpu6_mtimer.sv
`timescale 1ns/10ps
`include "cpu6_consts.svh"
`default_nettype none

module cpu6_mtimer (
   input  logic               clk,
   input  logic               rst_n,

   input  logic               csr_wr_en,
   input  logic               csr_rd_en,
   input  cpu6_pkg::csr_idx_t csr_idx,
   input  cpu6_pkg::xlen_t    csr_write_dat,

   output cpu6_pkg::xlen_t    timer_rd_dat,
   output logic               tmr_pend
);

   import cpu6_pkg::*;

   logic [2*`CPU6_XLEN-1:0] mtime_r;
   logic [2*`CPU6_XLEN-1:0] mtimecmp_r;
   logic                    sel_mtime;
   logic                    sel_mtimecmp;

   assign sel_mtime    = (csr_idx == `CPU6_CSR_MTIME);
   assign sel_mtimecmp = (csr_idx == `CPU6_CSR_MTIMECMP);

   // free running, no write path
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mtime_r <= '0;
      end else begin
         mtime_r <= mtime_r + 1'b1;
      end
   end

   // only the low word is writable, upper word goes to zero
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mtimecmp_r <= `CPU6_MTIMECMP_RST;
      end else if (csr_wr_en && sel_mtimecmp) begin
         mtimecmp_r <= {{`CPU6_XLEN{1'b0}}, csr_write_dat};
      end
   end

   // pending level, one cycle behind the compare
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tmr_pend <= 1'b0;
      end else begin
         tmr_pend <= (mtime_r >= mtimecmp_r);
      end
   end

   // zero unless one of our indices is read, csr block ors this in
   assign timer_rd_dat = ({`CPU6_XLEN{csr_rd_en & sel_mtime}} & mtime_r[`CPU6_XLEN-1:0])
                       | ({`CPU6_XLEN{csr_rd_en & sel_mtimecmp}}
                          & mtimecmp_r[`CPU6_XLEN-1:0]);

endmodule

`default_nettype wire

//--- rtl/cpu6_trap_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module cpu6_trap_ctrl (
   input  logic                 clk,
   input  logic                 rst_n,

   // commit stage
   input  logic                 instr_valid,
   input  cpu6_pkg::commit_op_e instr_op,
   input  cpu6_pkg::xlen_t      instr_pc,
   input  cpu6_pkg::csr_idx_t   instr_csr_idx,
   input  cpu6_pkg::xlen_t      instr_wdat,

   // interrupt sources and csr state
   input  logic                 ext_irq,
   input  logic                 tmr_pend,
   input  logic                 csr_mtie_r,
   input  logic                 csr_mstatus_mie_r,
   input  cpu6_pkg::xlen_t      csr_mtvec,
   input  cpu6_pkg::xlen_t      csr_mepc,
   input  cpu6_pkg::xlen_t      csr_read_dat,

   // csr access strobes
   output logic                 csr_rd_en,
   output logic                 csr_wr_en,
   output cpu6_pkg::csr_idx_t   csr_idx,
   output cpu6_pkg::xlen_t      csr_write_dat,
   output logic                 mret_ena,
   output logic                 trap_take,
   output logic                 excp_mepc_ena,
   output cpu6_pkg::xlen_t      excp_mepc,

   // back to the core
   output logic                 retire,
   output logic                 redirect,
   output cpu6_pkg::xlen_t      redirect_pc,
   output cpu6_pkg::xlen_t      rd_dat
);

   import cpu6_pkg::*;

   trap_state_e state_r;
   trap_state_e state_nxt;
   logic        irq_cond;
   logic        take_irq;
   logic        do_mret;
   logic        do_csr_wr;
   logic        do_csr_rd;
   logic        retire_r;
   xlen_t       redirect_pc_r;
   xlen_t       rd_dat_r;

   // global enable over external or enabled timer source
   assign irq_cond = csr_mstatus_mie_r & (ext_irq | (tmr_pend & csr_mtie_r));

   // an interrupt suppresses the instruction itself
   assign take_irq  = instr_valid & irq_cond;
   assign do_mret   = instr_valid & ~irq_cond & (instr_op == op_mret);
   assign do_csr_wr = instr_valid & ~irq_cond & (instr_op == op_csr_wr);
   assign do_csr_rd = instr_valid & ~irq_cond & (instr_op == op_csr_rd);

   // csr side effects land at the sampling edge
   assign csr_rd_en     = do_csr_rd;
   assign csr_wr_en     = do_csr_wr;
   assign csr_idx       = instr_csr_idx;
   assign csr_write_dat = instr_wdat;
   assign mret_ena      = do_mret;
   assign trap_take     = take_irq;
   assign excp_mepc_ena = take_irq;
   assign excp_mepc     = instr_pc;

   always_comb begin
      if (take_irq) begin
         state_nxt = st_enter;
      end else if (do_mret) begin
         state_nxt = st_return;
      end else begin
         state_nxt = st_run;
      end
   end

   // enter and return last exactly the redirect cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_r <= st_run;
      end else begin
         state_r <= state_nxt;
      end
   end

   // one result per committed instruction
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         retire_r      <= 1'b0;
         redirect_pc_r <= '0;
         rd_dat_r      <= '0;
      end else begin
         retire_r <= instr_valid & ~take_irq & ~do_mret;
         case (state_nxt)
            st_enter:  redirect_pc_r <= csr_mtvec;
            st_return: redirect_pc_r <= csr_mepc;
            default:   redirect_pc_r <= '0;
         endcase
         rd_dat_r <= do_csr_rd ? csr_read_dat : '0;
      end
   end

   assign retire      = retire_r;
   assign redirect    = (state_r == st_enter) || (state_r == st_return);
   assign redirect_pc = redirect_pc_r;
   assign rd_dat      = rd_dat_r;

   a_retire_or_redirect: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(retire && redirect)
   );

   a_pulse_per_instr: assert property (
      @(posedge clk) disable iff (!rst_n)
      instr_valid |=> (retire ^ redirect)
   );

endmodule

`default_nettype wire

//--- rtl/cpu6_trap_unit.sv
`timescale 1ns/10ps
`default_nettype none

module cpu6_trap_unit (
   input  logic                 clk,
   input  logic                 rst_n,

   input  logic                 instr_valid,
   input  cpu6_pkg::commit_op_e instr_op,
   input  cpu6_pkg::xlen_t      instr_pc,
   input  cpu6_pkg::csr_idx_t   instr_csr_idx,
   input  cpu6_pkg::xlen_t      instr_wdat,
   input  logic                 ext_irq,

   output logic                 retire,
   output logic                 redirect,
   output cpu6_pkg::xlen_t      redirect_pc,
   output cpu6_pkg::xlen_t      rd_dat
);

   import cpu6_pkg::*;

   logic     csr_rd_en;
   logic     csr_wr_en;
   csr_idx_t csr_idx;
   xlen_t    csr_write_dat;
   xlen_t    csr_read_dat;
   logic     mret_ena;
   logic     trap_take;
   logic     excp_mepc_ena;
   xlen_t    excp_mepc;
   logic     tmr_pend;
   xlen_t    timer_rd_dat;
   logic     csr_mtie_r;
   logic     csr_mstatus_mie_r;
   xlen_t    csr_mtvec;
   xlen_t    csr_mepc;

   cpu6_trap_ctrl u_trap_ctrl (
      .clk               (clk),
      .rst_n             (rst_n),
      .instr_valid       (instr_valid),
      .instr_op          (instr_op),
      .instr_pc          (instr_pc),
      .instr_csr_idx     (instr_csr_idx),
      .instr_wdat        (instr_wdat),
      .ext_irq           (ext_irq),
      .tmr_pend          (tmr_pend),
      .csr_mtie_r        (csr_mtie_r),
      .csr_mstatus_mie_r (csr_mstatus_mie_r),
      .csr_mtvec         (csr_mtvec),
      .csr_mepc          (csr_mepc),
      .csr_read_dat      (csr_read_dat),
      .csr_rd_en         (csr_rd_en),
      .csr_wr_en         (csr_wr_en),
      .csr_idx           (csr_idx),
      .csr_write_dat     (csr_write_dat),
      .mret_ena          (mret_ena),
      .trap_take         (trap_take),
      .excp_mepc_ena     (excp_mepc_ena),
      .excp_mepc         (excp_mepc),
      .retire            (retire),
      .redirect          (redirect),
      .redirect_pc       (redirect_pc),
      .rd_dat            (rd_dat)
   );

   cpu6_csr u_csr (
      .clk               (clk),
      .rst_n             (rst_n),
      .csr_rd_en         (csr_rd_en),
      .csr_wr_en         (csr_wr_en),
      .csr_idx           (csr_idx),
      .csr_write_dat     (csr_write_dat),
      .csr_read_dat      (csr_read_dat),
      .mret_ena          (mret_ena),
      .trap_take         (trap_take),
      .tmr_pend          (tmr_pend),
      .excp_mepc         (excp_mepc),
      .excp_mepc_ena     (excp_mepc_ena),
      .timer_rd_dat      (timer_rd_dat),
      .csr_mtie_r        (csr_mtie_r),
      .csr_mstatus_mie_r (csr_mstatus_mie_r),
      .csr_mtvec         (csr_mtvec),
      .csr_mepc          (csr_mepc)
   );

   cpu6_mtimer u_mtimer (
      .clk           (clk),
      .rst_n         (rst_n),
      .csr_wr_en     (csr_wr_en),
      .csr_rd_en     (csr_rd_en),
      .csr_idx       (csr_idx),
      .csr_write_dat (csr_write_dat),
      .timer_rd_dat  (timer_rd_dat),
      .tmr_pend      (tmr_pend)
   );

endmodule

`default_nettype wire

//--- sim/cpu6_trap_tb.sv
`timescale 1ns/10ps
`include "cpu6_consts.svh"
`default_nettype none

module cpu6_trap_tb;

   import cpu6_pkg::*;

   localparam int PULSE_LIMIT = 64;
   localparam int TIMER_LIMIT = 256;

   logic       clk = 1'b0;
   logic       rst_n;
   logic       instr_valid;
   commit_op_e instr_op;
   xlen_t      instr_pc;
   csr_idx_t   instr_csr_idx;
   xlen_t      instr_wdat;
   logic       ext_irq;
   logic       retire;
   logic       redirect;
   xlen_t      redirect_pc;
   xlen_t      rd_dat;

   int n_tests = 0;
   int n_errors = 0;
   bit timed_out = 1'b0;

   cpu6_trap_unit cpu6_trap_unit_i (
      .clk           (clk),
      .rst_n         (rst_n),
      .instr_valid   (instr_valid),
      .instr_op      (instr_op),
      .instr_pc      (instr_pc),
      .instr_csr_idx (instr_csr_idx),
      .instr_wdat    (instr_wdat),
      .ext_irq       (ext_irq),
      .retire        (retire),
      .redirect      (redirect),
      .redirect_pc   (redirect_pc),
      .rd_dat        (rd_dat)
   );

   // 100 ns period
   always #50 clk = ~clk;

   function automatic commit_op_e to_commit_op(input logic [3:0] code);
      case (code)
         4'd1:    return op_csr_rd;
         4'd2:    return op_csr_wr;
         4'd3:    return op_mret;
         default: return op_plain;
      endcase
   endfunction

   function automatic string op_name(input logic [3:0] code);
      case (code)
         4'd0:    return "plain";
         4'd1:    return "csr read";
         4'd2:    return "csr write";
         4'd3:    return "mret";
         4'd4:    return "timer run";
         default: return "unknown";
      endcase
   endfunction

   task automatic report_error(input string msg);
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      n_errors++;
   endtask

   task automatic check_retire(input xlen_t got, input xlen_t exp, input xlen_t pc);
      if (got !== exp) begin
         report_error($sformatf("pc %h retired with rd_dat %h, expected %h", pc, got, exp));
      end
   endtask

   task automatic check_redirect(input xlen_t got_pc, input xlen_t exp_pc, input xlen_t pc);
      if (got_pc !== exp_pc) begin
         report_error($sformatf("pc %h redirected to %h, expected %h", pc, got_pc, exp_pc));
      end
   endtask

   // one commit strobe sampled by the DUT at the second edge
   task automatic issue_instr(input commit_op_e op, input xlen_t pc, input csr_idx_t idx,
                              input xlen_t wdat, input logic irq);
      @(posedge clk);
      instr_valid   <= 1'b1;
      instr_op      <= op;
      instr_pc      <= pc;
      instr_csr_idx <= idx;
      instr_wdat    <= wdat;
      ext_irq       <= irq;
      @(posedge clk);
      instr_valid   <= 1'b0;
   endtask

   task automatic wait_pulse(input int limit, output bit seen, output int used);
      seen = 1'b0;
      used = 0;
      while (!seen && used < limit) begin
         @(negedge clk);
         used++;
         if (retire || redirect) begin
            seen = 1'b1;
         end
      end
   endtask

   // pulse seen at this falling edge, gone by the next one
   task automatic judge_outcome(input logic want_redirect, input xlen_t exp_val,
                                input xlen_t pc, input int used);
      if (used != 1) begin
         report_error($sformatf("pulse for pc %h came %0d cycles after the strobe, expected 1",
                                pc, used));
      end
      if (retire && redirect) begin
         report_error($sformatf("pc %h gave retire and redirect together", pc));
      end else if (want_redirect && redirect) begin
         check_redirect(redirect_pc, exp_val, pc);
      end else if (!want_redirect && retire) begin
         check_retire(rd_dat, exp_val, pc);
      end else begin
         report_error($sformatf("pc %h expected %s, got the other pulse", pc,
                                want_redirect ? "redirect" : "retire"));
      end
      @(negedge clk);
      if (retire || redirect) begin
         report_error($sformatf("pulse for pc %h lasted more than one cycle", pc));
      end
   endtask

   task automatic run_instr(input commit_op_e op, input xlen_t pc, input csr_idx_t idx,
                            input xlen_t wdat, input logic irq,
                            input logic want_redirect, input xlen_t exp_val);
      bit seen;
      int used;
      issue_instr(op, pc, idx, wdat, irq);
      wait_pulse(PULSE_LIMIT, seen, used);
      if (!seen) begin
         $display("timeout: no retire or redirect within %0d cycles of the instruction at pc %h",
                  PULSE_LIMIT, pc);
         timed_out = 1'b1;
      end else begin
         judge_outcome(want_redirect, exp_val, pc, used);
      end
   endtask

   // plain instructions until the timer traps and the handler reads mepc
   task automatic run_timer(input xlen_t start_pc, input logic irq, input xlen_t vec);
      xlen_t pc;
      xlen_t trap_pc;
      bit    seen;
      bit    hit;
      int    used;
      int    total;
      pc      = start_pc;
      trap_pc = '0;
      hit     = 1'b0;
      total   = 0;
      while (!hit && !timed_out && total < TIMER_LIMIT) begin
         issue_instr(op_plain, pc, '0, '0, irq);
         wait_pulse(PULSE_LIMIT, seen, used);
         total = total + used + 3;
         if (!seen) begin
            $display("timeout: no pulse within %0d cycles of the instruction at pc %h",
                     PULSE_LIMIT, pc);
            timed_out = 1'b1;
         end else begin
            hit = redirect;
            judge_outcome(hit, hit ? vec : '0, pc, used);
            if (hit) begin
               trap_pc = pc;
            end else begin
               pc = pc + 32'd4;
            end
         end
      end
      if (!hit && !timed_out) begin
         $display("timeout: no timer interrupt within %0d cycles", TIMER_LIMIT);
         timed_out = 1'b1;
      end else if (hit) begin
         $display("timer interrupt taken at pc %h", trap_pc);
         run_instr(op_csr_rd, vec, `CPU6_CSR_MEPC, '0, irq, 1'b0, trap_pc);
      end
   endtask

   initial begin
      string      line;
      int         fd;
      int         n;
      int         errors_before;
      logic [3:0] op_code;
      xlen_t      pc;
      csr_idx_t   idx;
      xlen_t      wdat;
      logic       irq;
      logic       kind;
      xlen_t      exp_val;

      rst_n         <= 1'b0;
      instr_valid   <= 1'b0;
      instr_op      <= op_plain;
      instr_pc      <= '0;
      instr_csr_idx <= '0;
      instr_wdat    <= '0;
      ext_irq       <= 1'b0;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;

      fd = $fopen("sim/trap_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open the pattern file sim/trap_patterns.txt");
         n_errors++;
      end else begin
         while (!timed_out && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // skip blank and comment lines
            if (line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h",
                           op_code, pc, idx, wdat, irq, kind, exp_val);
               if (n != 7 || op_code > 4'd4) begin
                  $display("pattern line could not be parsed: %s", line);
                  n_errors++;
               end else begin
                  n_tests++;
                  errors_before = n_errors;
                  if (op_code == 4'd4) begin
                     run_timer(pc, irq, exp_val);
                  end else begin
                     run_instr(to_commit_op(op_code), pc, idx, wdat, irq, kind, exp_val);
                  end
                  $display("test %0d %s pc %h idx %h: %s", n_tests, op_name(op_code), pc,
                           idx, (n_errors == errors_before && !timed_out) ? "ok" : "error");
               end
            end
         end
         $fclose(fd);
      end

      $display("tests run %0d, failed checks %0d, timeout %0d", n_tests, n_errors, timed_out);
      if (n_errors == 0 && !timed_out && n_tests > 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/trap_patterns.txt
# columns, all hex: op pc csr_idx wdat ext_irq kind expect
# op 0 plain, 1 csr read, 2 csr write, 3 mret, 4 timer run of plain instructions
# kind 0 retire with rd_dat = expect, 1 redirect with redirect_pc = expect
#
# csr round trip
2 00001000 304 000008a0 0 0 00000000
1 00001004 304 00000000 0 0 00000080
2 00001008 300 00001888 0 0 00000000
1 0000100c 300 00000000 0 0 00000008
2 00001010 341 00002345 0 0 00000000
1 00001014 341 00000000 0 0 00002344
1 00001018 344 00000000 0 0 00000000
0 0000101c 000 00000000 0 0 00000000
#
# external interrupt entry
0 00001020 000 00000000 1 1 00000100
1 00000100 341 00000000 1 0 00001020
1 00000104 300 00000000 1 0 00000000
#
# masked interrupt
0 00000108 000 00000000 1 0 00000000
2 0000010c 341 00003000 1 0 00000000
1 00000110 341 00000000 1 0 00003000
0 00000114 000 00000000 1 0 00000000
#
# mret back to mepc
3 00000118 000 00000000 0 1 00003000
1 00003000 300 00000000 0 0 00000008
#
# timer interrupt, mie off while mtimecmp changes
2 00003004 300 00000000 0 0 00000000
2 00003008 7c0 000000c0 0 0 00000000
1 0000300c 7c0 00000000 0 0 000000c0
2 00003010 304 00000080 0 0 00000000
2 00003014 300 00000008 0 0 00000000
4 00003018 000 00000000 0 1 00000100
1 00000104 344 00000000 0 0 00000080
# mtimecmp back to all ones clears mtip
2 00000108 7c0 ffffffff 0 0 00000000
0 0000010c 000 00000000 0 0 00000000
1 00000110 344 00000000 0 0 00000000

//--- sim.f
+incdir+rtl
rtl/cpu6_pkg.sv
rtl/cpu6_csr.sv
rtl/cpu6_mtimer.sv
rtl/cpu6_trap_ctrl.sv
rtl/cpu6_trap_unit.sv
sim/cpu6_trap_tb.sv

//--- Makefile
TOP := cpu6_trap_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
